// ==== hw/stream_xbar_pkg.sv ====
// Shared constants and types of the four by four stream crossbar.
// Every file reaches into this package with scoped names.
package stream_xbar_pkg;

  // Number of input ports of the crossbar.
  localparam int unsigned NUM_INP = 32'd4;

  // Number of output ports of the crossbar.
  // It is a power of two, so every select value names a real output.
  localparam int unsigned NUM_OUT = 32'd4;

  // Width of one beat payload in bits.
  localparam int unsigned DATA_WIDTH = 32'd16;

  // Width of the output select that travels with each input beat.
  localparam int unsigned SEL_WIDTH = (NUM_OUT > 32'd1) ? $clog2(NUM_OUT) : 32'd1;

  // Width of the source index reported at each output.
  localparam int unsigned IDX_WIDTH = (NUM_INP > 32'd1) ? $clog2(NUM_INP) : 32'd1;

  // One beat payload.
  typedef logic [DATA_WIDTH-1:0] payload_t;

  // Output select of an input beat.
  typedef logic [SEL_WIDTH-1:0] sel_oup_t;

  // Number of an input port.
  typedef logic [IDX_WIDTH-1:0] idx_inp_t;

  // Beat as stored in the output buffer.
  // The data sits in the upper bits and the source index in the lower bits.
  typedef struct packed {
    payload_t data;
    idx_inp_t idx;
  } xbar_beat_t;

endpackage

// ==== hw/rr_arbiter.sv ====
`timescale 1ns/1ps

// Round-robin arbiter for one crossbar output.
// The search starts at a priority pointer and wraps around the inputs.
// Once the outgoing valid is raised without a ready, the winner is frozen
// until the beat is taken, so the downstream side sees a stable beat.
module rr_arbiter #(
  parameter type data_t = stream_xbar_pkg::payload_t
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  // Request lines, one per input.
  input  logic  [stream_xbar_pkg::NUM_INP-1:0]  req_i,
  // Grant lines, one per input; a grant means the beat moves this cycle.
  output logic  [stream_xbar_pkg::NUM_INP-1:0]  gnt_o,
  // Payload offered by each input.
  input  data_t [stream_xbar_pkg::NUM_INP-1:0]  data_i,
  // Outgoing handshake towards the output buffer.
  output logic                                  valid_o,
  input  logic                                  ready_i,
  output data_t                                 data_o,
  output stream_xbar_pkg::idx_inp_t             idx_o
);

  // Priority pointer; the search for a winner begins here.
  stream_xbar_pkg::idx_inp_t ptr_q;
  // Pointer value after the current winner is accepted.
  stream_xbar_pkg::idx_inp_t ptr_d;

  // Lock state; set while a presented beat waits for ready.
  logic                      lock_q;
  stream_xbar_pkg::idx_inp_t lock_idx_q;

  // Result of the round-robin search over the live requests.
  stream_xbar_pkg::idx_inp_t search_idx;
  logic                      search_hit;

  // Winner actually used this cycle.
  stream_xbar_pkg::idx_inp_t win_idx;

  // Handshake completion on the outgoing side.
  logic                      accept;
  logic                      stall;

  // Scan the inputs upward from the pointer and take the first request.
  // The index wraps modulo the input count.
  always_comb begin : proc_search
    int unsigned cand;
    cand       = 0;
    search_idx = ptr_q;
    search_hit = 1'b0;
    for (int unsigned k = 0; k < stream_xbar_pkg::NUM_INP; k++) begin
      cand = (32'(ptr_q) + k) % stream_xbar_pkg::NUM_INP;
      if (!search_hit && req_i[cand]) begin
        search_hit = 1'b1;
        search_idx = stream_xbar_pkg::idx_inp_t'(cand);
      end
    end
  end

  // A locked choice overrides the search.
  // Senders keep valid high until the grant, so the locked input still requests.
  assign win_idx = lock_q ? lock_idx_q : search_idx;
  assign valid_o = lock_q || search_hit;

  // Forward the winner's payload and number.
  assign data_o = data_i[win_idx];
  assign idx_o  = win_idx;

  assign accept = valid_o && ready_i;
  assign stall  = valid_o && !ready_i;

  // Only the winner sees a grant, and only when the buffer takes the beat.
  always_comb begin : proc_grant
    gnt_o = '0;
    if (accept) begin
      gnt_o[win_idx] = 1'b1;
    end
  end

  // The next search starts just past the winner.
  always_comb begin : proc_ptr_next
    if (32'(win_idx) == stream_xbar_pkg::NUM_INP - 32'd1) begin
      ptr_d = '0;
    end else begin
      ptr_d = win_idx + stream_xbar_pkg::idx_inp_t'(1);
    end
  end

  // Pointer and lock update on the clock edge.
  always_ff @(posedge clk_i) begin : proc_state
    if (!rst_n_i) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      // The lock lasts exactly as long as the beat waits.
      lock_q <= stall;
      if (stall) begin
        lock_idx_q <= win_idx;
      end
      // The pointer only moves on a completed transfer.
      if (accept) begin
        ptr_q <= ptr_d;
      end
    end
  end

endmodule

// ==== hw/spill_register.sv ====
`timescale 1ns/1ps

// Two-entry output buffer that registers the beat and cuts the ready path.
// The main slot takes every new beat.
// The skid slot catches a beat from the main slot when the output stalls,
// so the upstream side can send one more beat after ready drops.
module spill_register #(
  parameter type data_t = stream_xbar_pkg::xbar_beat_t
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Upstream handshake.
  input  logic  valid_i,
  output logic  ready_o,
  input  data_t data_i,
  // Downstream handshake.
  output logic  valid_o,
  input  logic  ready_i,
  output data_t data_o
);

  // Main slot, written by every accepted input beat.
  data_t main_q;
  logic  main_full_q;
  logic  main_fill;
  logic  main_drain;

  // Skid slot, which always holds the older beat when both are full.
  data_t skid_q;
  logic  skid_full_q;
  logic  skid_fill;
  logic  skid_drain;

  // A new beat is taken whenever at least one slot is free.
  // This looks only at the flags, never at ready_i.
  assign ready_o   = !main_full_q || !skid_full_q;
  assign main_fill = valid_i && ready_o;

  // With the skid slot empty, the main slot is the head of the queue.
  // Its beat leaves this cycle, either to the output or into the skid slot.
  assign main_drain = main_full_q && !skid_full_q;

  // A head beat that the output refuses is parked in the skid slot.
  assign skid_fill  = main_drain && !ready_i;
  assign skid_drain = skid_full_q && ready_i;

  // The oldest beat is presented first.
  assign valid_o = main_full_q || skid_full_q;
  assign data_o  = skid_full_q ? skid_q : main_q;

  // Occupancy flags.
  always_ff @(posedge clk_i) begin : proc_flags
    if (!rst_n_i) begin
      main_full_q <= 1'b0;
      skid_full_q <= 1'b0;
    end else begin
      // A fill and a drain in one cycle keep the slot full with the new beat.
      main_full_q <= main_fill || (main_full_q && !main_drain);
      skid_full_q <= skid_fill || (skid_full_q && !skid_drain);
    end
  end

  // Payload storage.
  always_ff @(posedge clk_i) begin : proc_data
    if (main_fill) begin
      main_q <= data_i;
    end
    if (skid_fill) begin
      skid_q <= main_q;
    end
  end

endmodule

// ==== hw/stream_xbar.sv ====
`timescale 1ns/1ps

// Fully connected stream crossbar with four inputs and four outputs.
// Each input beat names its output through sel_i.
// Every output has its own round-robin arbiter and a two-entry buffer.
// Routing and arbitration are combinational; the buffer adds one cycle.
module stream_xbar (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  // Input ports.
  input  stream_xbar_pkg::payload_t [stream_xbar_pkg::NUM_INP-1:0] data_i,
  input  stream_xbar_pkg::sel_oup_t [stream_xbar_pkg::NUM_INP-1:0] sel_i,
  input  logic                      [stream_xbar_pkg::NUM_INP-1:0] valid_i,
  output logic                      [stream_xbar_pkg::NUM_INP-1:0] ready_o,
  // Output ports.
  output stream_xbar_pkg::payload_t [stream_xbar_pkg::NUM_OUT-1:0] data_o,
  output stream_xbar_pkg::idx_inp_t [stream_xbar_pkg::NUM_OUT-1:0] idx_o,
  output logic                      [stream_xbar_pkg::NUM_OUT-1:0] valid_o,
  input  logic                      [stream_xbar_pkg::NUM_OUT-1:0] ready_i
);

  // Request and grant lines, indexed by output first and input second.
  logic [stream_xbar_pkg::NUM_OUT-1:0][stream_xbar_pkg::NUM_INP-1:0] out_req;
  logic [stream_xbar_pkg::NUM_OUT-1:0][stream_xbar_pkg::NUM_INP-1:0] out_gnt;

  // Input side: decode each select into one request line.
  for (genvar i = 0; i < int'(stream_xbar_pkg::NUM_INP); i++) begin : gen_inps
    for (genvar j = 0; j < int'(stream_xbar_pkg::NUM_OUT); j++) begin : gen_cross
      // Only the selected output sees the valid of this input.
      assign out_req[j][i] = valid_i[i] && (sel_i[i] == stream_xbar_pkg::sel_oup_t'(j));
    end
    // The ready comes back from the arbiter of the selected output.
    // An idle input requests nothing, so its grant and its ready stay low.
    assign ready_o[i] = out_gnt[sel_i[i]][i];
  end

  // Output side: arbitration followed by the buffer.
  for (genvar j = 0; j < int'(stream_xbar_pkg::NUM_OUT); j++) begin : gen_outs
    // Winner beat between arbiter and buffer.
    stream_xbar_pkg::xbar_beat_t arb_beat;
    logic                        arb_valid;
    logic                        arb_ready;
    // Beat presented by the buffer at the output port.
    stream_xbar_pkg::xbar_beat_t out_beat;

    // Every arbiter sees the data of all inputs.
    // Only the requests differ between outputs.
    rr_arbiter #(
      .data_t ( stream_xbar_pkg::payload_t )
    ) i_rr_arbiter (
      .clk_i   ( clk_i         ),
      .rst_n_i ( rst_n_i       ),
      .req_i   ( out_req[j]    ),
      .gnt_o   ( out_gnt[j]    ),
      .data_i  ( data_i        ),
      .valid_o ( arb_valid     ),
      .ready_i ( arb_ready     ),
      .data_o  ( arb_beat.data ),
      .idx_o   ( arb_beat.idx  )
    );

    // The buffer carries the payload together with its source number.
    spill_register #(
      .data_t ( stream_xbar_pkg::xbar_beat_t )
    ) i_spill_register (
      .clk_i   ( clk_i      ),
      .rst_n_i ( rst_n_i    ),
      .valid_i ( arb_valid  ),
      .ready_o ( arb_ready  ),
      .data_i  ( arb_beat   ),
      .valid_o ( valid_o[j] ),
      .ready_i ( ready_i[j] ),
      .data_o  ( out_beat   )
    );

    // Split the stored beat back onto the output ports.
    assign data_o[j] = out_beat.data;
    assign idx_o[j]  = out_beat.idx;
  end

endmodule

// ==== verification/stream_xbar_tb.sv ====
`timescale 1ns/1ps

// Testbench for the four by four stream crossbar.
// Stimulus and expected output beats come from a trace file.
// Tests run one after the other, and a test ends when every input queue is
// empty and every expected beat has been seen.
module stream_xbar_tb;

  localparam int    CLK_PERIOD     = 8;
  localparam string TRACE_PATH     = "verification/stream_xbar_trace.txt";
  localparam int    SEED           = 32'h61b82ffd;
  localparam int    TIMEOUT_MARGIN = 100;
  localparam int    NI             = int'(stream_xbar_pkg::NUM_INP);
  localparam int    NO             = int'(stream_xbar_pkg::NUM_OUT);
  localparam int    MAX_BEATS      = 16;
  // Output and duration of the stall in the back-pressure test.
  localparam int    BP_OUT         = 1;
  localparam int    BP_CYCLES      = 10;

  logic                                           clk_i;
  logic                                           rst_n_i;
  stream_xbar_pkg::payload_t [NI-1:0]             data_i;
  stream_xbar_pkg::sel_oup_t [NI-1:0]             sel_i;
  logic                      [NI-1:0]             valid_i;
  logic                      [NI-1:0]             ready_o;
  stream_xbar_pkg::payload_t [NO-1:0]             data_o;
  stream_xbar_pkg::idx_inp_t [NO-1:0]             idx_o;
  logic                      [NO-1:0]             valid_o;
  logic                      [NO-1:0]             ready_i;

  // Trace contents as flat lists with a test number per record.
  string test_names[$];
  int    in_test[$];
  int    in_port[$];
  int    in_sel[$];
  int    in_data[$];
  int    out_test[$];
  int    out_port[$];
  int    out_idx[$];
  int    out_data[$];

  // Beats of the running test for each input and each output.
  int    drv_sel[NI][MAX_BEATS];
  int    drv_data[NI][MAX_BEATS];
  int    drv_cnt[NI];
  int    drv_pos[NI];
  int    exp_idx[NO][MAX_BEATS];
  int    exp_data[NO][MAX_BEATS];
  bit    exp_used[NO][MAX_BEATS];
  int    exp_cnt[NO];
  int    exp_taken[NO];

  string cur_name;
  bit    running;
  int    cyc;
  int    test_cyc;
  int    limit;
  int    acc_cyc;
  int    last_take[NO];
  logic  [NO-1:0] stall_q;
  stream_xbar_pkg::payload_t prev_data[NO];
  stream_xbar_pkg::idx_inp_t prev_idx[NO];
  int    err_value;
  int    err_other;

  stream_xbar i_stream_xbar (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .data_i  ( data_i  ),
    .sel_i   ( sel_i   ),
    .valid_i ( valid_i ),
    .ready_o ( ready_o ),
    .data_o  ( data_o  ),
    .idx_o   ( idx_o   ),
    .valid_o ( valid_o ),
    .ready_i ( ready_i )
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Reads every record of the trace; lines that start with # are skipped.
  task automatic read_trace();
    int    fd;
    int    code;
    string kind;
    string name;
    string rest;
    int    port;
    int    field;
    int    value;
    fd = $fopen(TRACE_PATH, "r");
    if (fd == 0) begin
      $display("Could not open the trace file %s", TRACE_PATH);
      err_other++;
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", kind);
      if (code != 1) break;
      if (kind == "#") begin
        code = $fgets(rest, fd);
      end else begin
        code = $fscanf(fd, "%s %d %d %h", name, port, field, value);
        if (code != 4) begin
          $display("A trace record after kind %s could not be parsed", kind);
          err_other++;
          break;
        end
        // A new test starts wherever the name changes.
        if (test_names.size() == 0 || test_names[test_names.size() - 1] != name) begin
          test_names.push_back(name);
        end
        if (kind == "I") begin
          in_test.push_back(test_names.size() - 1);
          in_port.push_back(port);
          in_sel.push_back(field);
          in_data.push_back(value);
        end else if (kind == "O") begin
          out_test.push_back(test_names.size() - 1);
          out_port.push_back(port);
          out_idx.push_back(field);
          out_data.push_back(value);
        end else begin
          $display("The trace holds a record of unknown kind %s", kind);
          err_other++;
        end
      end
    end
    $fclose(fd);
  endtask

  // Copies the records of one test into the per-port tables.
  task automatic load_test(input int t);
    int p;
    for (int i = 0; i < NI; i++) begin
      drv_cnt[i] = 0;
      drv_pos[i] = 0;
    end
    for (int j = 0; j < NO; j++) begin
      exp_cnt[j]   = 0;
      exp_taken[j] = 0;
      last_take[j] = 0;
      for (int k = 0; k < MAX_BEATS; k++) exp_used[j][k] = 1'b0;
    end
    for (int r = 0; r < in_test.size(); r++) begin
      if (in_test[r] == t) begin
        p = in_port[r];
        drv_sel[p][drv_cnt[p]]  = in_sel[r];
        drv_data[p][drv_cnt[p]] = in_data[r];
        drv_cnt[p]++;
      end
    end
    for (int r = 0; r < out_test.size(); r++) begin
      if (out_test[r] == t) begin
        p = out_port[r];
        exp_idx[p][exp_cnt[p]]  = out_idx[r];
        exp_data[p][exp_cnt[p]] = out_data[r];
        exp_cnt[p]++;
      end
    end
    cur_name = test_names[t];
    test_cyc = 0;
  endtask

  function automatic bit test_done();
    bit done;
    done = 1'b1;
    for (int i = 0; i < NI; i++) if (drv_pos[i] < drv_cnt[i]) done = 1'b0;
    for (int j = 0; j < NO; j++) if (exp_taken[j] < exp_cnt[j]) done = 1'b0;
    return done;
  endfunction

  // Lists every output whose expected beats did not all arrive.
  task automatic report_missing();
    for (int j = 0; j < NO; j++) begin
      if (exp_taken[j] < exp_cnt[j]) begin
        $display("Output %0d is missing %0d beats in test %s",
                 j, exp_cnt[j] - exp_taken[j], cur_name);
        err_other++;
      end
    end
  endtask

  // Compares one beat taken at output j with the expected list.
  // The stress test only keeps the order within each source input.
  task automatic check_beat(input int j, input int idx, input int data);
    int hit;
    hit = -1;
    if (cur_name == "stress") begin
      for (int k = 0; k < exp_cnt[j]; k++) begin
        if (hit < 0 && !exp_used[j][k] && exp_idx[j][k] == idx) hit = k;
      end
    end else if (exp_taken[j] < exp_cnt[j]) begin
      hit = exp_taken[j];
    end
    if (hit < 0) begin
      $display("Unexpected beat at output %0d from input %0d in test %s", j, idx, cur_name);
      err_other++;
    end else begin
      exp_used[j][hit] = 1'b1;
      exp_taken[j]++;
      if (idx != exp_idx[j][hit] || data != exp_data[j][hit]) begin
        $display("[ERROR] %s: output %0d expected idx %0d data %h, actual idx %0d data %h",
                 cur_name, j, exp_idx[j][hit], exp_data[j][hit][15:0], idx, data[15:0]);
        err_value++;
      end
    end
    // An empty buffer delays a beat by exactly one cycle.
    if (cur_name == "latency" && cyc != acc_cyc + 1) begin
      $display("[ERROR] %s: expected latency 1, actual %0d", cur_name, cyc - acc_cyc);
      err_value++;
    end
    // Full routing keeps every output busy on every cycle.
    if (cur_name == "routing" && exp_taken[j] > 1 && cyc != last_take[j] + 1) begin
      $display("Output %0d went idle between beats in test routing", j);
      err_other++;
    end
    last_take[j] = cyc;
  endtask

  // Inputs change on the falling edge only.
  always @(negedge clk_i) begin
    if (running) begin
      for (int i = 0; i < NI; i++) begin
        if (drv_pos[i] < drv_cnt[i]) begin
          valid_i[i] = 1'b1;
          sel_i[i]   = stream_xbar_pkg::sel_oup_t'(drv_sel[i][drv_pos[i]]);
          data_i[i]  = stream_xbar_pkg::payload_t'(drv_data[i][drv_pos[i]]);
        end else begin
          valid_i[i] = 1'b0;
        end
      end
      for (int j = 0; j < NO; j++) begin
        if (cur_name == "backpressure" && j == BP_OUT && test_cyc < BP_CYCLES) begin
          ready_i[j] = 1'b0;
        end else if (cur_name == "stress") begin
          ready_i[j] = ($urandom % 4) != 0;
        end else begin
          ready_i[j] = 1'b1;
        end
      end
    end else begin
      valid_i = '0;
      ready_i = '1;
    end
  end

  // Handshakes are sampled on the rising edge.
  always @(posedge clk_i) begin
    cyc++;
    test_cyc++;
    if (!rst_n_i) begin
      // The flags are cleared by the first reset edge, so checking starts at the second.
      if (cyc > 1 && valid_o !== '0) begin
        $display("An output was valid during reset");
        err_other++;
      end
    end else begin
      for (int j = 0; j < NO; j++) begin
        // A waiting beat must not move or vanish.
        if (stall_q[j] && (!valid_o[j] || data_o[j] != prev_data[j]
                           || idx_o[j] != prev_idx[j])) begin
          $display("Output %0d changed its beat while it was stalled", j);
          err_other++;
        end
        if (valid_o[j] && ready_i[j]) check_beat(j, int'(idx_o[j]), int'(data_o[j]));
        stall_q[j]   = valid_o[j] && !ready_i[j];
        prev_data[j] = data_o[j];
        prev_idx[j]  = idx_o[j];
      end
      for (int i = 0; i < NI; i++) begin
        if (valid_i[i] && ready_o[i]) begin
          drv_pos[i]++;
          acc_cyc = cyc;
        end
      end
    end
    if (cyc >= limit) begin
      $display("Timeout after %0d cycles with beats still outstanding", cyc);
      err_other++;
      report_missing();
      $display("Errors: %0d wrong values, %0d other failures", err_value, err_other);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    rst_n_i   = 1'b0;
    data_i    = '0;
    sel_i     = '0;
    valid_i   = '0;
    ready_i   = '1;
    running   = 1'b0;
    cur_name  = "reset";
    cyc       = 0;
    test_cyc  = 0;
    acc_cyc   = 0;
    err_value = 0;
    err_other = 0;
    stall_q   = '0;
    limit     = 1000000;
    void'($urandom(SEED));
    read_trace();
    limit = 20 * in_data.size() + TIMEOUT_MARGIN;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    repeat (2) @(posedge clk_i);
    #1;
    for (int t = 0; t < test_names.size(); t++) begin
      load_test(t);
      running = 1'b1;
      while (!test_done()) begin
        @(posedge clk_i);
        #1;
      end
    end
    repeat (3) @(posedge clk_i);
    $display("Errors: %0d wrong values, %0d other failures", err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== verification/stream_xbar_trace.txt ====
# I test input select data   : a beat that the input sends, in order per input
# O test output idx data     : a beat expected at the output, in order per output
I latency 1 2 1010
O latency 2 1 1010
I routing 0 0 2000
I routing 0 1 2001
I routing 0 2 2002
I routing 0 3 2003
I routing 1 1 2010
I routing 1 2 2011
I routing 1 3 2012
I routing 1 0 2013
I routing 2 2 2020
I routing 2 3 2021
I routing 2 0 2022
I routing 2 1 2023
I routing 3 3 2030
I routing 3 0 2031
I routing 3 1 2032
I routing 3 2 2033
O routing 0 0 2000
O routing 0 3 2031
O routing 0 2 2022
O routing 0 1 2013
O routing 1 1 2010
O routing 1 0 2001
O routing 1 3 2032
O routing 1 2 2023
O routing 2 2 2020
O routing 2 1 2011
O routing 2 0 2002
O routing 2 3 2033
O routing 3 3 2030
O routing 3 2 2021
O routing 3 1 2012
O routing 3 0 2003
I fairness 0 2 3000
I fairness 0 2 3001
I fairness 0 2 3002
I fairness 1 2 3010
I fairness 1 2 3011
I fairness 1 2 3012
I fairness 2 2 3020
I fairness 2 2 3021
I fairness 2 2 3022
I fairness 3 2 3030
I fairness 3 2 3031
I fairness 3 2 3032
O fairness 2 0 3000
O fairness 2 1 3010
O fairness 2 2 3020
O fairness 2 3 3030
O fairness 2 0 3001
O fairness 2 1 3011
O fairness 2 2 3021
O fairness 2 3 3031
O fairness 2 0 3002
O fairness 2 1 3012
O fairness 2 2 3022
O fairness 2 3 3032
I backpressure 0 1 4000
I backpressure 0 1 4001
I backpressure 0 1 4002
I backpressure 2 1 4020
I backpressure 2 1 4021
I backpressure 2 1 4022
O backpressure 1 0 4000
O backpressure 1 2 4020
O backpressure 1 0 4001
O backpressure 1 2 4021
O backpressure 1 0 4002
O backpressure 1 2 4022
I stress 0 3 5000
I stress 0 3 5001
I stress 1 3 5010
I stress 1 0 5011
I stress 2 0 5020
I stress 2 3 5021
I stress 3 1 5030
I stress 3 3 5031
O stress 3 0 5000
O stress 3 0 5001
O stress 3 1 5010
O stress 3 2 5021
O stress 3 3 5031
O stress 0 1 5011
O stress 0 2 5020
O stress 1 3 5030

// ==== stream_xbar.f ====
hw/stream_xbar_pkg.sv
hw/rr_arbiter.sv
hw/spill_register.sv
hw/stream_xbar.sv
verification/stream_xbar_tb.sv

// ==== run_stream_xbar.sh ====
#!/usr/bin/env bash
# Builds the crossbar simulation with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary -Wno-fatal -f stream_xbar.f --top-module stream_xbar_tb \
  --Mdir obj_dir -o stream_xbar_sim > build.log 2>&1 \
  && ./obj_dir/stream_xbar_sim > sim.log 2>&1 \
  || echo "Build or simulation did not complete, see build.log and sim.log"

grep -qx "All tests passed!" sim.log \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED, see sim.log"; exit 1; }
